// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [31:0]     instr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_op_e;

  typedef enum logic {
    src_a_reg,
    src_a_pc
  } alu_src_a_e;

  typedef enum logic {
    src_b_reg,
    src_b_imm
  } alu_src_b_e;

  typedef enum logic [1:0] {
    result_alu,
    result_pc_plus_4,
    result_load
  } result_src_e;

  // Encoded as the branch funct3
  typedef enum logic [2:0] {
    cond_eq  = 3'b000,
    cond_ne  = 3'b001,
    cond_lt  = 3'b100,
    cond_ge  = 3'b101,
    cond_ltu = 3'b110,
    cond_geu = 3'b111
  } branch_cond_e;

  typedef enum logic {
    jump_pc_imm,
    jump_alu
  } jump_src_e;

  // Low two bits of the load/store funct3
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_mem  = 2'b01,
    fwd_wb   = 2'b10
  } forward_e;

endpackage

// ==== hw/cpu_decoder.sv ====
`timescale 1ns/1ps

module cpu_decoder (
  input  cpu_pkg::instr_t       instr,
  output logic                  reg_write,
  output logic                  mem_read,
  output logic                  mem_write,
  output cpu_pkg::mem_size_e    mem_size,
  output logic                  mem_unsigned,
  output logic                  jump,
  output logic                  branch,
  output cpu_pkg::branch_cond_e branch_cond,
  output cpu_pkg::jump_src_e    jump_src,
  output cpu_pkg::alu_op_e      alu_op,
  output cpu_pkg::alu_src_a_e   alu_src_a,
  output cpu_pkg::alu_src_b_e   alu_src_b,
  output cpu_pkg::result_src_e  result_src,
  output cpu_pkg::word_t        imm
);
  import cpu_pkg::*;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_op_e    arith_op;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // Subtract exists only in register form; bit 30 picks sra for both forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = funct7_5 ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    reg_write    = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    mem_size     = mem_size_e'(funct3[1:0]);
    mem_unsigned = funct3[2];
    jump         = 1'b0;
    branch       = 1'b0;
    branch_cond  = branch_cond_e'(funct3);
    jump_src     = jump_pc_imm;
    alu_op       = alu_add;
    alu_src_a    = src_a_reg;
    alu_src_b    = src_b_imm;
    result_src   = result_alu;
    imm          = imm_i;

    case (opcode)
      op_lui: begin
        reg_write = 1'b1;
        alu_op    = alu_pass_b;
        imm       = imm_u;
      end
      op_auipc: begin
        reg_write = 1'b1;
        alu_src_a = src_a_pc;
        imm       = imm_u;
      end
      op_jal: begin
        reg_write  = 1'b1;
        jump       = 1'b1;
        result_src = result_pc_plus_4;
        imm        = imm_j;
      end
      op_jalr: begin
        reg_write  = 1'b1;
        jump       = 1'b1;
        jump_src   = jump_alu;
        result_src = result_pc_plus_4;
      end
      op_branch: begin
        // funct3 010 and 011 are reserved
        branch    = funct3[2:1] != 2'b01;
        alu_op    = alu_sub;
        alu_src_b = src_b_reg;
        imm       = imm_b;
      end
      op_load: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          reg_write  = 1'b1;
          mem_read   = 1'b1;
          result_src = result_load;
        end
      end
      op_store: begin
        mem_write = funct3 inside {3'b000, 3'b001, 3'b010};
        imm       = imm_s;
      end
      op_imm: begin
        reg_write = 1'b1;
        alu_op    = arith_op;
      end
      op_reg: begin
        reg_write = 1'b1;
        alu_op    = arith_op;
        alu_src_b = src_b_reg;
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu #(
  parameter int XLEN = cpu_pkg::xlen
) (
  input  cpu_pkg::word_t   src_a,
  input  cpu_pkg::word_t   src_b,
  input  cpu_pkg::alu_op_e op,
  output cpu_pkg::word_t   result,
  output logic             zero,
  output logic             neg,
  output logic             carry,
  output logic             overflow
);
  import cpu_pkg::*;

  localparam int shamt_w = $clog2(XLEN);

  logic [XLEN:0]      diff;
  logic [shamt_w-1:0] shamt;
  logic               lt;

  // Flags always come from a - b, whatever op is selected
  assign diff     = {1'b0, src_a} + {1'b0, ~src_b} + 1'b1;
  assign zero     = diff[XLEN-1:0] == '0;
  assign neg      = diff[XLEN-1];
  assign carry    = diff[XLEN];
  assign overflow = (src_a[XLEN-1] ^ src_b[XLEN-1]) & (diff[XLEN-1] ^ src_a[XLEN-1]);
  assign lt       = neg ^ overflow;
  assign shamt    = src_b[shamt_w-1:0];

  always_comb begin
    case (op)
      alu_add:    result = src_a + src_b;
      alu_sub:    result = diff[XLEN-1:0];
      alu_and:    result = src_a & src_b;
      alu_or:     result = src_a | src_b;
      alu_xor:    result = src_a ^ src_b;
      alu_sll:    result = src_a << shamt;
      alu_srl:    result = src_a >> shamt;
      alu_sra:    result = $signed(src_a) >>> shamt;
      alu_slt:    result = word_t'(lt);
      alu_sltu:   result = word_t'(!carry);
      alu_pass_b: result = src_b;
      default:    result = '0;
    endcase
  end

endmodule

// ==== hw/cpu_register_file.sv ====
`timescale 1ns/1ps

module cpu_register_file #(
  parameter int XLEN = cpu_pkg::xlen
) (
  input  logic               clk,
  input  cpu_pkg::reg_addr_t rs1,
  input  cpu_pkg::reg_addr_t rs2,
  input  cpu_pkg::reg_addr_t rd,
  input  cpu_pkg::word_t     wdata,
  input  logic               we,
  output cpu_pkg::word_t     rdata1,
  output cpu_pkg::word_t     rdata2
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Writeback value bypasses to a read of the same index
  assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

// ==== hw/cpu_hazard_unit.sv ====
`timescale 1ns/1ps

module cpu_hazard_unit (
  input  cpu_pkg::reg_addr_t rs1_d,
  input  cpu_pkg::reg_addr_t rs2_d,
  input  cpu_pkg::reg_addr_t rs1_e,
  input  cpu_pkg::reg_addr_t rs2_e,
  input  cpu_pkg::reg_addr_t rd_e,
  input  cpu_pkg::reg_addr_t rd_m,
  input  cpu_pkg::reg_addr_t rd_w,
  input  logic               mem_read_e,
  input  logic               reg_write_m,
  input  logic               reg_write_w,
  input  logic               redirect_e,
  output cpu_pkg::forward_e  forward_a,
  output cpu_pkg::forward_e  forward_b,
  output logic               stall_f,
  output logic               stall_d,
  output logic               flush_d,
  output logic               flush_e
);
  import cpu_pkg::*;

  logic load_use;

  // Younger result wins
  function automatic forward_e forward_sel(input reg_addr_t rs, input reg_addr_t dst_m,
                                           input logic wr_m, input reg_addr_t dst_w,
                                           input logic wr_w);
    if (wr_m && dst_m != '0 && dst_m == rs) begin
      return fwd_mem;
    end
    if (wr_w && dst_w != '0 && dst_w == rs) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  assign forward_a = forward_sel(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
  assign forward_b = forward_sel(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

  assign load_use = mem_read_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

  // Hold fetch and decode, send a bubble into execute
  assign stall_f = load_use;
  assign stall_d = load_use;
  assign flush_d = redirect_e;
  assign flush_e = redirect_e | load_use;

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
  parameter int XLEN = cpu_pkg::xlen
) (
  input  logic              clk,
  input  logic              rst_n,
  output cpu_pkg::word_t    instr_addr,
  input  cpu_pkg::instr_t   instr_data,
  output cpu_pkg::word_t    data_addr,
  output cpu_pkg::word_t    data_wdata,
  output cpu_pkg::byte_en_t data_wenable,
  input  cpu_pkg::word_t    data_rdata
);
  import cpu_pkg::*;

  localparam word_t  reset_vector = '0;
  localparam instr_t nop_instr    = 32'h0000_0013;

  forward_e     forward_a_x;
  forward_e     forward_b_x;
  logic         stall_f;
  logic         stall_d;
  logic         flush_d;
  logic         flush_e;

  // Fetch
  word_t        pc_f;
  word_t        pc_next_f;

  // Decode
  instr_t       instr_d;
  word_t        pc_d;
  reg_addr_t    rs1_d;
  reg_addr_t    rs2_d;
  logic         reg_write_d;
  logic         mem_read_d;
  logic         mem_write_d;
  mem_size_e    mem_size_d;
  logic         mem_unsigned_d;
  logic         jump_d;
  logic         branch_d;
  branch_cond_e branch_cond_d;
  jump_src_e    jump_src_d;
  alu_op_e      alu_op_d;
  alu_src_a_e   alu_src_a_d;
  alu_src_b_e   alu_src_b_d;
  result_src_e  result_src_d;
  word_t        imm_d;
  word_t        rd1_d;
  word_t        rd2_d;

  // Execute
  logic         reg_write_x;
  logic         mem_read_x;
  logic         mem_write_x;
  logic         jump_x;
  logic         branch_x;
  mem_size_e    mem_size_x;
  logic         mem_unsigned_x;
  branch_cond_e branch_cond_x;
  jump_src_e    jump_src_x;
  alu_op_e      alu_op_x;
  alu_src_a_e   alu_src_a_x;
  alu_src_b_e   alu_src_b_x;
  result_src_e  result_src_x;
  word_t        imm_x;
  word_t        rd1_x;
  word_t        rd2_x;
  word_t        pc_x;
  reg_addr_t    rs1_x;
  reg_addr_t    rs2_x;
  reg_addr_t    rd_x;
  word_t        opnd1_x;
  word_t        opnd2_x;
  word_t        alu_result_x;
  logic         alu_zero_x;
  logic         alu_neg_x;
  logic         alu_carry_x;
  logic         alu_overflow_x;
  logic         taken_x;
  logic         redirect_x;
  word_t        target_x;

  // Memory
  logic         reg_write_m;
  logic         mem_write_m;
  mem_size_e    mem_size_m;
  logic         mem_unsigned_m;
  result_src_e  result_src_m;
  word_t        alu_result_m;
  word_t        store_data_m;
  word_t        pc_plus_4_m;
  reg_addr_t    rd_m;
  logic [1:0]   byte_off_m;
  byte_en_t     store_be_m;
  word_t        load_shifted_m;
  word_t        load_data_m;
  word_t        result_pre_m;

  // Writeback
  logic         reg_write_w;
  reg_addr_t    rd_w;
  result_src_e  result_src_w;
  word_t        result_pre_w;
  word_t        load_data_w;
  word_t        result_w;

  function automatic word_t forward_mux(input forward_e sel, input word_t reg_val,
                                        input word_t mem_val, input word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // Fall-through unless execute redirects
  assign pc_next_f  = redirect_x ? target_x : pc_f + 32'd4;
  assign instr_addr = pc_f;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= reset_vector;
    end else if (!stall_f) begin
      pc_f <= pc_next_f;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_d) begin
      instr_d <= nop_instr;
    end else if (!stall_d) begin
      instr_d <= instr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d <= pc_f;
    end
  end

  assign rs1_d = instr_d[19:15];
  assign rs2_d = instr_d[24:20];

  cpu_decoder decoder_i (
    .instr        (instr_d),
    .reg_write    (reg_write_d),
    .mem_read     (mem_read_d),
    .mem_write    (mem_write_d),
    .mem_size     (mem_size_d),
    .mem_unsigned (mem_unsigned_d),
    .jump         (jump_d),
    .branch       (branch_d),
    .branch_cond  (branch_cond_d),
    .jump_src     (jump_src_d),
    .alu_op       (alu_op_d),
    .alu_src_a    (alu_src_a_d),
    .alu_src_b    (alu_src_b_d),
    .result_src   (result_src_d),
    .imm          (imm_d)
  );

  cpu_register_file #(
    .XLEN (XLEN)
  ) register_file_i (
    .clk    (clk),
    .rs1    (rs1_d),
    .rs2    (rs2_d),
    .rd     (rd_w),
    .wdata  (result_w),
    .we     (reg_write_w),
    .rdata1 (rd1_d),
    .rdata2 (rd2_d)
  );

  // Effect flags are cleared on a bubble, the rest just follows decode
  always_ff @(posedge clk) begin
    if (!rst_n || flush_e) begin
      reg_write_x <= 1'b0;
      mem_read_x  <= 1'b0;
      mem_write_x <= 1'b0;
      jump_x      <= 1'b0;
      branch_x    <= 1'b0;
    end else begin
      reg_write_x <= reg_write_d;
      mem_read_x  <= mem_read_d;
      mem_write_x <= mem_write_d;
      jump_x      <= jump_d;
      branch_x    <= branch_d;
    end
  end

  always_ff @(posedge clk) begin
    mem_size_x     <= mem_size_d;
    mem_unsigned_x <= mem_unsigned_d;
    branch_cond_x  <= branch_cond_d;
    jump_src_x     <= jump_src_d;
    alu_op_x       <= alu_op_d;
    alu_src_a_x    <= alu_src_a_d;
    alu_src_b_x    <= alu_src_b_d;
    result_src_x   <= result_src_d;
    imm_x          <= imm_d;
    rd1_x          <= rd1_d;
    rd2_x          <= rd2_d;
    pc_x           <= pc_d;
    rs1_x          <= rs1_d;
    rs2_x          <= rs2_d;
    rd_x           <= instr_d[11:7];
  end

  assign opnd1_x = forward_mux(forward_a_x, rd1_x, result_pre_m, result_w);
  assign opnd2_x = forward_mux(forward_b_x, rd2_x, result_pre_m, result_w);

  cpu_alu #(
    .XLEN (XLEN)
  ) alu_i (
    .src_a    ((alu_src_a_x == src_a_pc) ? pc_x : opnd1_x),
    .src_b    ((alu_src_b_x == src_b_imm) ? imm_x : opnd2_x),
    .op       (alu_op_x),
    .result   (alu_result_x),
    .zero     (alu_zero_x),
    .neg      (alu_neg_x),
    .carry    (alu_carry_x),
    .overflow (alu_overflow_x)
  );

  always_comb begin
    case (branch_cond_x)
      cond_eq:  taken_x = alu_zero_x;
      cond_ne:  taken_x = ~alu_zero_x;
      cond_lt:  taken_x = alu_neg_x ^ alu_overflow_x;
      cond_ge:  taken_x = ~(alu_neg_x ^ alu_overflow_x);
      cond_ltu: taken_x = ~alu_carry_x;
      cond_geu: taken_x = alu_carry_x;
      default:  taken_x = 1'b0;
    endcase
  end

  assign redirect_x = jump_x | (branch_x & taken_x);
  assign target_x   = (jump_src_x == jump_alu) ? {alu_result_x[XLEN-1:1], 1'b0} : pc_x + imm_x;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_m <= 1'b0;
      mem_write_m <= 1'b0;
    end else begin
      reg_write_m <= reg_write_x;
      mem_write_m <= mem_write_x;
    end
  end

  always_ff @(posedge clk) begin
    mem_size_m     <= mem_size_x;
    mem_unsigned_m <= mem_unsigned_x;
    result_src_m   <= result_src_x;
    alu_result_m   <= alu_result_x;
    store_data_m   <= opnd2_x;
    pc_plus_4_m    <= pc_x + 32'd4;
    rd_m           <= rd_x;
  end

  assign byte_off_m = alu_result_m[1:0];

  // Store lanes follow the low address bits
  always_comb begin
    case (mem_size_m)
      size_byte: begin
        store_be_m = 4'b0001 << byte_off_m;
        data_wdata = word_t'(store_data_m[7:0]) << {byte_off_m, 3'b000};
      end
      size_half: begin
        store_be_m = 4'b0011 << {byte_off_m[1], 1'b0};
        data_wdata = word_t'(store_data_m[15:0]) << {byte_off_m[1], 4'b0000};
      end
      default: begin
        store_be_m = 4'b1111;
        data_wdata = store_data_m;
      end
    endcase
  end

  assign data_addr      = alu_result_m;
  assign data_wenable   = mem_write_m ? store_be_m : '0;
  assign load_shifted_m = data_rdata >> {byte_off_m, 3'b000};

  always_comb begin
    case (mem_size_m)
      size_byte: load_data_m = {{(XLEN-8){load_shifted_m[7] & ~mem_unsigned_m}},
                                load_shifted_m[7:0]};
      size_half: load_data_m = {{(XLEN-16){load_shifted_m[15] & ~mem_unsigned_m}},
                                load_shifted_m[15:0]};
      default:   load_data_m = data_rdata;
    endcase
  end

  // Loads never forward from here, the stall covers them
  assign result_pre_m = (result_src_m == result_pc_plus_4) ? pc_plus_4_m : alu_result_m;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_w <= 1'b0;
    end else begin
      reg_write_w <= reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    rd_w         <= rd_m;
    result_src_w <= result_src_m;
    result_pre_w <= result_pre_m;
    load_data_w  <= load_data_m;
  end

  assign result_w = (result_src_w == result_load) ? load_data_w : result_pre_w;

  cpu_hazard_unit hazard_unit_i (
    .rs1_d       (rs1_d),
    .rs2_d       (rs2_d),
    .rs1_e       (rs1_x),
    .rs2_e       (rs2_x),
    .rd_e        (rd_x),
    .rd_m        (rd_m),
    .rd_w        (rd_w),
    .mem_read_e  (mem_read_x),
    .reg_write_m (reg_write_m),
    .reg_write_w (reg_write_w),
    .redirect_e  (redirect_x),
    .forward_a   (forward_a_x),
    .forward_b   (forward_b_x),
    .stall_f     (stall_f),
    .stall_d     (stall_d),
    .flush_d     (flush_d),
    .flush_e     (flush_e)
  );

endmodule

// ==== test/cpu_ref_model.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    word_t r;
    case (f3)
      3'b000: begin
        if (alt) begin
          r = a - b;
        end else begin
          r = a + b;
        end
      end
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Runs the program one instruction at a time and queues every store
  task automatic run_model();
    word_t      x [32];
    word_t      mem [256];
    word_t      pc;
    word_t      next_pc;
    instr_t     ins;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      shifted;
    word_t      wval;
    word_t      sdata;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    byte_en_t   be;
    logic       wr;
    logic       take;
    logic [2:0] f3;
    reg_addr_t  rd;
    int         steps;
    for (int n = 0; n < 32; n++) begin
      x[n] = '0;
    end
    for (int n = 0; n < 256; n++) begin
      mem[n] = fill_word(n);
    end
    pc    = '0;
    steps = 0;
    while (pc != halt_pc) begin
      assert (steps < cycle_limit) else begin
        abort_run("Reference model did not reach the final self-jump");
      end
      ins   = imem[pc[9:2]];
      f3    = ins[14:12];
      rd    = ins[11:7];
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_u = {ins[31:12], 12'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 32'd4;
      wr      = 1'b1;
      wval    = '0;
      case (ins[6:0])
        7'b0110111: wval = imm_u;
        7'b0010111: wval = pc + imm_u;
        7'b1101111: begin
          wval    = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        7'b1100111: begin
          wval    = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          wr = 1'b0;
          case (f3)
            3'b000:  take = a == b;
            3'b001:  take = a != b;
            3'b100:  take = $signed(a) < $signed(b);
            3'b101:  take = $signed(a) >= $signed(b);
            3'b110:  take = a < b;
            3'b111:  take = a >= b;
            default: take = 1'b0;
          endcase
          if (take) begin
            next_pc = pc + imm_b;
          end
        end
        7'b0000011: begin
          addr    = a + imm_i;
          shifted = mem[addr[9:2]] >> (8 * addr[1:0]);
          case (f3)
            3'b000:  wval = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  wval = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  wval = {24'b0, shifted[7:0]};
            3'b101:  wval = {16'b0, shifted[15:0]};
            default: wval = mem[addr[9:2]];
          endcase
        end
        7'b0100011: begin
          wr   = 1'b0;
          addr = a + imm_s;
          case (f3)
            3'b000: begin
              be    = 4'b0001 << addr[1:0];
              sdata = word_t'(b[7:0]) << (8 * addr[1:0]);
            end
            3'b001: begin
              be    = 4'b0011 << addr[1:0];
              sdata = word_t'(b[15:0]) << (8 * addr[1:0]);
            end
            default: begin
              be    = 4'b1111;
              sdata = b;
            end
          endcase
          for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
              mem[addr[9:2]][8*k +: 8] = sdata[8*k +: 8];
            end
          end
          exp_addr.push_back(addr);
          exp_data.push_back(sdata);
          exp_be.push_back(be);
        end
        7'b0010011: wval = ref_alu(f3, f3 == 3'b101 && ins[30], a, imm_i);
        7'b0110011: wval = ref_alu(f3, ins[30], a, b);
        default:    wr = 1'b0;
      endcase
      if (wr && rd != '0) begin
        x[rd] = wval;
      end
      pc = next_pc;
      steps++;
    end
  endtask

`endif

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int          prog_len    = 200;
  localparam int          dump_start  = prog_len - 32;
  localparam int          halt_index  = prog_len - 1;
  localparam int          cycle_limit = 4 * prog_len + 100;
  localparam word_t       halt_pc     = word_t'(halt_index * 4);
  localparam word_t       data_base   = 32'h0000_1000;
  localparam instr_t      nop_instr   = 32'h0000_0013;
  localparam logic [31:0] lfsr_seed   = 32'd85906;
  localparam logic [31:0] lfsr_mask   = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  word_t       instr_addr;
  instr_t      instr_data;
  word_t       data_addr;
  word_t       data_wdata;
  byte_en_t    data_wenable;
  word_t       data_rdata;

  instr_t      imem [256];
  word_t       dmem [256];
  logic [31:0] lfsr_state;
  word_t       exp_addr [$];
  word_t       exp_data [$];
  byte_en_t    exp_be [$];
  int          exp_idx;
  int          cycles;
  logic        done;

  cpu #(
    .XLEN (xlen)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_addr   (instr_addr),
    .instr_data   (instr_data),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_wenable (data_wenable),
    .data_rdata   (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign instr_data = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (data_wenable[b]) begin
        dmem[data_addr[9:2]][8*b +: 8] <= data_wdata[8*b +: 8];
      end
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic value_error(input string name, input word_t got, input word_t want);
    abort_run($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                        $time, name, got, want));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ lfsr_mask;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  function automatic word_t fill_word(input int idx);
    word_t a;
    a = data_base + word_t'(idx * 4);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic instr_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x1 holds the data base and x31 the zero base for JALR
  function automatic reg_addr_t pick_dest();
    return reg_addr_t'(rand_bits(5) % 29 + 2);
  endfunction

  // Half the time reuse the last result to exercise forwarding
  function automatic reg_addr_t pick_source(input reg_addr_t recent);
    if (rand_bits(1) != 0) begin
      return recent;
    end
    return reg_addr_t'(rand_bits(5));
  endfunction

  function automatic int forward_target(input int from);
    int t;
    t = from + 1 + int'(rand_bits(2));
    if (t > dump_start) begin
      t = dump_start;
    end
    return t;
  endfunction

  function automatic logic [7:0] aligned_offset(input logic [2:0] f3);
    logic [7:0] off;
    off = 8'(rand_bits(8));
    if (f3[1:0] == 2'b01) begin
      off[0] = 1'b0;
    end else if (f3[1:0] == 2'b10) begin
      off[1:0] = 2'b00;
    end
    return off;
  endfunction

  task automatic build_program();
    int          i;
    int          tgt;
    int          sel;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   last_rd;
    for (int n = 0; n < 256; n++) begin
      imem[n] = nop_instr;
    end
    imem[0] = u_type(20'h00001, 5'd1, 7'b0110111);
    for (int r = 2; r <= 30; r++) begin
      imem[r - 1] = i_type(12'(rand_bits(12)), 5'd0, 3'b000, reg_addr_t'(r), 7'b0010011);
    end
    imem[30] = i_type(12'd0, 5'd0, 3'b000, 5'd31, 7'b0010011);
    last_rd = 5'd2;
    i = 31;
    while (i < dump_start) begin
      kind = 4'(rand_bits(4));
      rd   = pick_dest();
      rs1  = pick_source(last_rd);
      rs2  = pick_source(last_rd);
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
          f3  = 3'(rand_bits(3));
          alt = (f3 == 3'b000 || f3 == 3'b101) ? rand_bits(1) != 0 : 1'b0;
          imem[i] = r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end
        4'd5, 4'd6, 4'd7: begin
          f3  = 3'(rand_bits(3));
          imm = 12'(rand_bits(12));
          if (f3 == 3'b001) begin
            imm = {7'b0, imm[4:0]};
          end else if (f3 == 3'b101) begin
            imm = {1'b0, imm[10], 5'b0, imm[4:0]};
          end
          imem[i] = i_type(imm, rs1, f3, rd, 7'b0010011);
        end
        4'd8: imem[i] = u_type(20'(rand_bits(20)), rd, 7'b0110111);
        4'd9: imem[i] = u_type(20'(rand_bits(20)), rd, 7'b0010111);
        4'd10, 4'd11: begin
          sel = int'(rand_bits(3) % 5);
          f3  = (sel < 3) ? 3'(sel) : 3'(sel + 1);
          imem[i] = i_type({4'b0, aligned_offset(f3)}, 5'd1, f3, rd, 7'b0000011);
        end
        4'd12, 4'd13: begin
          f3 = 3'(rand_bits(2) % 3);
          imem[i] = s_type({4'b0, aligned_offset(f3)}, rs2, 5'd1, f3);
        end
        4'd14: begin
          tgt = forward_target(i);
          if (rand_bits(1) != 0) begin
            f3 = 3'(rand_bits(3));
            if (f3[2:1] == 2'b01) begin
              f3 = {1'b1, f3[1:0]};
            end
            imem[i] = b_type(13'((tgt - i) * 4), rs2, rs1, f3);
          end else begin
            imem[i] = j_type(21'((tgt - i) * 4), rd);
          end
        end
        default: begin
          if (i + 1 < dump_start) begin
            imem[i] = u_type(20'd0, 5'd31, 7'b0110111);
            tgt = forward_target(i + 1);
            // Odd offset checks that bit 0 of the target is cleared
            imem[i + 1] = i_type(12'(tgt * 4 + int'(rand_bits(1))), 5'd31, 3'b000, rd,
                                 7'b1100111);
            i++;
          end
        end
      endcase
      if (kind < 4'd12 || kind == 4'd14) begin
        last_rd = rd;
      end
      i++;
    end
    for (int r = 1; r <= 31; r++) begin
      imem[dump_start + r - 1] = s_type(12'(256 + 4 * (r - 1)), reg_addr_t'(r), 5'd1, 3'b010);
    end
    imem[halt_index] = j_type(21'd0, 5'd0);
  endtask

  `include "cpu_ref_model.svh"

  task automatic check_store();
    assert (exp_idx < exp_addr.size()) else begin
      abort_run($sformatf("Store to 0x%08h after the last expected store", data_addr));
    end
    assert (data_addr == exp_addr[exp_idx]) else begin
      value_error("data_addr", data_addr, exp_addr[exp_idx]);
    end
    assert (data_wenable == exp_be[exp_idx]) else begin
      value_error("data_wenable", word_t'(data_wenable), word_t'(exp_be[exp_idx]));
    end
    assert (data_wdata == exp_data[exp_idx]) else begin
      value_error("data_wdata", data_wdata, exp_data[exp_idx]);
    end
    exp_idx++;
  endtask

  initial begin
    rst_n      = 1'b0;
    lfsr_state = lfsr_seed;
    exp_idx    = 0;
    cycles     = 0;
    done       = 1'b0;
    for (int n = 0; n < 256; n++) begin
      dmem[n] = fill_word(n);
    end
    build_program();
    run_model();

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (instr_addr == '0) else begin
      value_error("instr_addr", instr_addr, '0);
    end

    while (!done && cycles < cycle_limit) begin
      @(negedge clk);
      cycles++;
      assert (!$isunknown(data_wenable)) else begin
        abort_run("data_wenable is unknown after reset");
      end
      if (data_wenable != '0) begin
        check_store();
      end
      done = (exp_idx == exp_addr.size()) && (instr_addr == halt_pc);
    end

    if (done) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run($sformatf("Timeout: the program did not reach its final jump in %0d cycles",
                          cycle_limit));
    end
  end

endmodule

// ==== src.f ====
+incdir+test
hw/cpu_pkg.sv
hw/cpu_decoder.sv
hw/cpu_alu.sv
hw/cpu_register_file.sv
hw/cpu_hazard_unit.sv
hw/cpu.sv
test/cpu_tb.sv
